// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tbSingleCycleCpu \
    -f src.f

output=$(./obj_dir/VtbSingleCycleCpu)
echo "$output"

if grep -qx "Testbench passed" <<< "$output"; then
    exit 0
fi
exit 1

// File: src.f
+incdir+test
src/rvPkg.sv
src/instrDecode.sv
src/aluUnit.sv
src/branchUnit.sv
src/regFile.sv
src/loadStoreUnit.sv
src/singleCycleCpu.sv
test/tbSingleCycleCpu.sv

// File: src/aluUnit.sv
`timescale 1ns/10ps

module aluUnit (
    input  rvPkg::decodedInstr     dec,
    input  logic [rvPkg::xlen-1:0] rs1Data,
    input  logic [rvPkg::xlen-1:0] rs2Data,
    output logic [rvPkg::xlen-1:0] aluResult
);

    logic [rvPkg::xlen-1:0] opA;
    logic [rvPkg::xlen-1:0] opB;
    logic [4:0]             shamt;
    logic                   ltSigned;
    logic                   ltUnsigned;

    assign opA   = rs1Data;
    assign opB   = dec.useImm ? dec.imm : rs2Data;
    assign shamt = opB[4:0]; // low five bits only

    assign ltSigned   = $signed(opA) < $signed(opB);
    assign ltUnsigned = opA < opB;

    always_comb begin
        case (dec.aluOp)
            rvPkg::aluAdd: begin
                aluResult = opA + opB;
            end
            rvPkg::aluSub: begin
                aluResult = opA - opB;
            end
            rvPkg::aluSll: begin
                aluResult = opA << shamt;
            end
            rvPkg::aluSlt: begin
                aluResult = {{(rvPkg::xlen-1){1'b0}}, ltSigned};
            end
            rvPkg::aluSltu: begin
                aluResult = {{(rvPkg::xlen-1){1'b0}}, ltUnsigned};
            end
            rvPkg::aluXor: begin
                aluResult = opA ^ opB;
            end
            rvPkg::aluSrl: begin
                aluResult = opA >> shamt;
            end
            rvPkg::aluSra: begin
                aluResult = $unsigned($signed(opA) >>> shamt); // sign fill
            end
            rvPkg::aluOr: begin
                aluResult = opA | opB;
            end
            rvPkg::aluAnd: begin
                aluResult = opA & opB;
            end
            rvPkg::aluPassB: begin
                aluResult = opB; // lui immediate
            end
            default: begin
                aluResult = opA + opB;
            end
        endcase
    end

endmodule

// File: src/branchUnit.sv
`timescale 1ns/10ps

module branchUnit (
    input  logic [rvPkg::xlen-1:0] pc,
    input  rvPkg::decodedInstr     dec,
    input  logic [rvPkg::xlen-1:0] rs1Data,
    input  logic [rvPkg::xlen-1:0] rs2Data,
    output logic [rvPkg::xlen-1:0] nextPc,
    output logic [rvPkg::xlen-1:0] linkPc
);

    logic                   taken;
    logic [rvPkg::xlen-1:0] pcRel;
    logic [rvPkg::xlen-1:0] jalrSum;

    assign linkPc  = pc + rvPkg::instrBytes;
    assign pcRel   = pc + dec.imm;      // jal and branch target
    assign jalrSum = rs1Data + dec.imm;

    always_comb begin
        case (dec.funct3)
            rvPkg::f3Beq:  taken = (rs1Data == rs2Data);
            rvPkg::f3Bne:  taken = (rs1Data != rs2Data);
            rvPkg::f3Blt:  taken = $signed(rs1Data) < $signed(rs2Data);
            rvPkg::f3Bge:  taken = $signed(rs1Data) >= $signed(rs2Data);
            rvPkg::f3Bltu: taken = rs1Data < rs2Data;
            rvPkg::f3Bgeu: taken = rs1Data >= rs2Data;
            default:       taken = 1'b0; // illegal, decode halts
        endcase
    end

    always_comb begin
        case (dec.opcode)
            rvPkg::opJal: begin
                nextPc = pcRel;
            end
            rvPkg::opJalr: begin
                nextPc = {jalrSum[rvPkg::xlen-1:1], 1'b0}; // clear bit 0
            end
            rvPkg::opBranch: begin
                nextPc = taken ? pcRel : linkPc;
            end
            default: begin
                nextPc = linkPc;
            end
        endcase
    end

endmodule

// File: src/instrDecode.sv
`timescale 1ns/10ps

module instrDecode (
    input  logic [rvPkg::xlen-1:0] instr,
    output rvPkg::decodedInstr     dec
);

    logic [6:0]             funct7;
    logic [rvPkg::xlen-1:0] immI;
    logic [rvPkg::xlen-1:0] immS;
    logic [rvPkg::xlen-1:0] immB;
    logic [rvPkg::xlen-1:0] immU;
    logic [rvPkg::xlen-1:0] immJ;
    logic                   knownOp;
    logic                   badFunct;

    // funct3 plus the alternate bit picks the alu operation
    function automatic rvPkg::aluOpE aluFromFunct(input logic [2:0] f3, input logic alt);
        rvPkg::aluOpE op;
        case (f3)
            rvPkg::f3AddSub: op = alt ? rvPkg::aluSub : rvPkg::aluAdd;
            rvPkg::f3Sll:    op = rvPkg::aluSll;
            rvPkg::f3Slt:    op = rvPkg::aluSlt;
            rvPkg::f3Sltu:   op = rvPkg::aluSltu;
            rvPkg::f3Xor:    op = rvPkg::aluXor;
            rvPkg::f3SrlSra: op = alt ? rvPkg::aluSra : rvPkg::aluSrl;
            rvPkg::f3Or:     op = rvPkg::aluOr;
            default:         op = rvPkg::aluAnd;
        endcase
        return op;
    endfunction

    assign funct7 = instr[31:25];

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        dec          = '0;
        dec.opcode   = rvPkg::opcodeE'(instr[6:0]);
        dec.funct3   = instr[14:12];
        dec.rd       = instr[11:7];
        dec.rs1      = instr[19:15];
        dec.rs2      = instr[24:20];
        dec.aluOp    = rvPkg::aluAdd;
        knownOp      = 1'b1;
        badFunct     = 1'b0;
        case (dec.opcode)
            rvPkg::opLui: begin
                dec.imm      = immU;
                dec.aluOp    = rvPkg::aluPassB;
                dec.useImm   = 1'b1;
                dec.regWrite = 1'b1;
            end
            rvPkg::opAuipc: begin
                dec.imm      = immU; // sum formed in top
                dec.regWrite = 1'b1;
            end
            rvPkg::opJal: begin
                dec.imm      = immJ;
                dec.regWrite = 1'b1;
            end
            rvPkg::opJalr: begin
                dec.imm      = immI;
                dec.regWrite = 1'b1;
                badFunct     = (dec.funct3 != rvPkg::f3Jalr);
            end
            rvPkg::opBranch: begin
                dec.imm  = immB;
                badFunct = (dec.funct3 == 3'b010) || (dec.funct3 == 3'b011);
            end
            rvPkg::opLoad: begin
                dec.imm      = immI;
                dec.useImm   = 1'b1;
                dec.regWrite = 1'b1;
                badFunct     = (dec.funct3 != rvPkg::f3Word);
            end
            rvPkg::opStore: begin
                dec.imm    = immS;
                dec.useImm = 1'b1;
                badFunct   = (dec.funct3 != rvPkg::f3Word);
            end
            rvPkg::opOpImm: begin
                dec.imm      = immI;
                dec.useImm   = 1'b1;
                dec.regWrite = 1'b1;
                // only the shift forms carry instr[30] as a selector
                dec.aluOp    = aluFromFunct(dec.funct3,
                                            (dec.funct3 == rvPkg::f3SrlSra) && instr[30]);
                badFunct     = ((dec.funct3 == rvPkg::f3Sll) && (funct7 != rvPkg::f7Zero)) ||
                               ((dec.funct3 == rvPkg::f3SrlSra) && (funct7 != rvPkg::f7Zero)
                                && (funct7 != rvPkg::f7Alt));
            end
            rvPkg::opOp: begin
                dec.regWrite = 1'b1;
                dec.aluOp    = aluFromFunct(dec.funct3, instr[30]);
                badFunct     = (funct7 != rvPkg::f7Zero) &&
                               !((funct7 == rvPkg::f7Alt) &&
                                 ((dec.funct3 == rvPkg::f3AddSub) ||
                                  (dec.funct3 == rvPkg::f3SrlSra)));
            end
            default: knownOp = 1'b0;
        endcase
        dec.illegal = !knownOp || badFunct;
    end

endmodule

// File: src/loadStoreUnit.sv
`timescale 1ns/10ps

module loadStoreUnit (
    input  rvPkg::decodedInstr     dec,
    input  logic [rvPkg::xlen-1:0] rs1Data,
    input  logic [rvPkg::xlen-1:0] rs2Data,
    input  logic                   halt,
    output rvPkg::dataReq          dReq,
    output logic                   misaligned
);

    logic                   isLoad;
    logic                   isStore;
    logic [rvPkg::xlen-1:0] effAddr;

    assign isLoad  = (dec.opcode == rvPkg::opLoad);
    assign isStore = (dec.opcode == rvPkg::opStore);
    assign effAddr = rs1Data + dec.imm; // imm already i or s form

    assign misaligned = (isLoad || isStore) && (effAddr[1:0] != 2'b00);

    assign dReq.addr  = (isLoad || isStore) ? effAddr : '0;
    assign dReq.wdata = isStore ? rs2Data : '0;
    assign dReq.wen   = isStore && !halt;

    // halt comes from the top, so this ties its misaligned path back here
    always_comb begin
        if (dReq.wen) begin
            storeAligned: assert (dReq.addr[1:0] == 2'b00);
        end
    end

endmodule

// File: src/regFile.sv
`timescale 1ns/10ps

module regFile (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [rvPkg::regAddrW-1:0] rs1,
    input  logic [rvPkg::regAddrW-1:0] rs2,
    input  logic [rvPkg::regAddrW-1:0] rd,
    input  logic                       wen,
    input  logic [rvPkg::xlen-1:0]     wdata,
    output logic [rvPkg::xlen-1:0]     rs1Data,
    output logic [rvPkg::xlen-1:0]     rs2Data
);

    logic [rvPkg::xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (rd != '0)) begin
            regs[rd] <= wdata; // x0 is never written
        end
    end

    assign rs1Data = regs[rs1];
    assign rs2Data = regs[rs2];

    // the write filter keeps x0 at zero on both ports
    x0StaysZero: assert property (@(posedge clk) disable iff (!rst)
        ((rs1 != '0) || (rs1Data == '0)) && ((rs2 != '0) || (rs2Data == '0)));

endmodule

// File: src/rvPkg.sv
package rvPkg;

    localparam int xlen       = 32; // word and address width
    localparam int regAddrW   = 5;
    localparam int instrBytes = 4;  // pc step

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opBranch = 7'b1100011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opOpImm  = 7'b0010011,
        opOp     = 7'b0110011
    } opcodeE;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd,
        aluPassB // lui
    } aluOpE;

    // arithmetic funct3
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3SrlSra = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    // branch funct3
    localparam logic [2:0] f3Beq  = 3'b000;
    localparam logic [2:0] f3Bne  = 3'b001;
    localparam logic [2:0] f3Blt  = 3'b100;
    localparam logic [2:0] f3Bge  = 3'b101;
    localparam logic [2:0] f3Bltu = 3'b110;
    localparam logic [2:0] f3Bgeu = 3'b111;

    localparam logic [2:0] f3Word = 3'b010; // lw / sw only
    localparam logic [2:0] f3Jalr = 3'b000;

    localparam logic [6:0] f7Zero = 7'b0000000;
    localparam logic [6:0] f7Alt  = 7'b0100000; // sub, sra

    typedef struct packed {
        opcodeE                opcode;
        logic [2:0]            funct3;
        logic [regAddrW-1:0]   rd;
        logic [regAddrW-1:0]   rs1;
        logic [regAddrW-1:0]   rs2;
        logic [xlen-1:0]       imm;
        aluOpE                 aluOp;
        logic                  useImm;   // operand b from imm
        logic                  regWrite;
        logic                  illegal;
    } decodedInstr;

    typedef struct packed {
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
        logic            wen;
    } dataReq;

endpackage

// File: src/singleCycleCpu.sv
`timescale 1ns/10ps

module singleCycleCpu #(
    parameter logic [rvPkg::xlen-1:0] resetAddr = '0
) (
    input  logic                   clk,
    input  logic                   rst,
    output logic [rvPkg::xlen-1:0] pc,
    input  logic [rvPkg::xlen-1:0] instr,
    output rvPkg::dataReq          dReq,
    input  logic [rvPkg::xlen-1:0] dRdata,
    output logic                   halt
);

    rvPkg::decodedInstr     dec;
    logic [rvPkg::xlen-1:0] rs1Data;
    logic [rvPkg::xlen-1:0] rs2Data;
    logic [rvPkg::xlen-1:0] aluResult;
    logic [rvPkg::xlen-1:0] nextPc;
    logic [rvPkg::xlen-1:0] linkPc;
    logic [rvPkg::xlen-1:0] wbData;
    logic                   misaligned;
    logic                   rfWen;
    logic                   storeBlock;

    always_ff @(posedge clk) begin
        if (!rst) begin
            pc <= resetAddr;
        end else if (!halt) begin
            pc <= nextPc; // hold forever once halted
        end
    end

    assign halt       = dec.illegal || misaligned;
    assign storeBlock = halt || !rst;                  // no writes out of reset
    assign rfWen      = dec.regWrite && !halt && rst;

    always_comb begin
        case (dec.opcode)
            rvPkg::opAuipc: wbData = pc + dec.imm;
            rvPkg::opJal:   wbData = linkPc;
            rvPkg::opJalr:  wbData = linkPc;
            rvPkg::opLoad:  wbData = dRdata;
            default:        wbData = aluResult; // op, opimm, lui
        endcase
    end

    instrDecode u_decode (
        .instr (instr),
        .dec   (dec)
    );

    regFile u_regFile (
        .clk     (clk),
        .rst     (rst),
        .rs1     (dec.rs1),
        .rs2     (dec.rs2),
        .rd      (dec.rd),
        .wen     (rfWen),
        .wdata   (wbData),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    aluUnit u_alu (
        .dec       (dec),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data),
        .aluResult (aluResult)
    );

    branchUnit u_branch (
        .pc      (pc),
        .dec     (dec),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .nextPc  (nextPc),
        .linkPc  (linkPc)
    );

    loadStoreUnit u_lsu (
        .dec        (dec),
        .rs1Data    (rs1Data),
        .rs2Data    (rs2Data),
        .halt       (storeBlock),
        .dReq       (dReq),
        .misaligned (misaligned)
    );

    // frozen registers keep the same instruction halting
    pcHoldsOnHalt: assert property (@(posedge clk) disable iff (!rst)
        halt |=> (halt && $stable(pc)));

endmodule

// File: test/isaModel.svh
// reference model, steps one instruction per call over its own state
localparam logic [31:0] dataBase = 32'h0000_1000; // 64-word data window

logic [31:0] mRegs [32];
logic [31:0] mMem [64];
logic [31:0] mPc;
logic [31:0] expPc;
logic [31:0] expAddr;
logic [31:0] expWdata;
logic        expWen;
logic        expHalt;

function automatic logic [31:0] fillWord(input logic [31:0] addr);
    return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
endfunction

function automatic logic [31:0] arith(input logic [2:0] f3, input logic alt,
                                      input logic [31:0] x, input logic [31:0] y);
    case (f3)
        3'd0: return alt ? x - y : x + y;
        3'd1: return x << y[4:0];
        3'd2: return {31'b0, $signed(x) < $signed(y)};
        3'd3: return {31'b0, x < y};
        3'd4: return x ^ y;
        3'd5: return alt ? 32'($signed(x) >>> y[4:0]) : x >> y[4:0];
        3'd6: return x | y;
        default: return x & y;
    endcase
endfunction

task automatic modelReset();
    foreach (mRegs[i]) mRegs[i] = '0;
    foreach (mMem[i]) mMem[i] = fillWord(dataBase + 32'(i * 4));
    mPc = resetPc;
endtask

task automatic modelStep();
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] immJ;
    logic [31:0] res;
    logic [31:0] next;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic        wr;
    logic        bad;
    logic        tk;
    w    = imem[mPc[9:2]];
    f3   = w[14:12];
    f7   = w[31:25];
    a    = mRegs[w[19:15]];
    b    = mRegs[w[24:20]];
    immI = 32'($signed(w[31:20]));
    immS = 32'($signed({w[31:25], w[11:7]}));
    immB = 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
    immJ = 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
    next = mPc + 32'd4;
    res  = '0;
    wr   = 1'b0;
    bad  = 1'b0;
    tk   = 1'b0;
    expPc    = mPc;
    expWen   = 1'b0;
    expAddr  = '0;
    expWdata = '0;
    case (w[6:0])
        7'h37: begin
            res = {w[31:12], 12'h0};
            wr  = 1'b1;
        end
        7'h17: begin
            res = mPc + {w[31:12], 12'h0};
            wr  = 1'b1;
        end
        7'h6f: begin
            res  = mPc + 32'd4;
            wr   = 1'b1;
            next = mPc + immJ;
        end
        7'h67: begin
            res  = mPc + 32'd4;
            wr   = 1'b1;
            next = (a + immI) & ~32'h1;
            bad  = (f3 != 3'd0);
        end
        7'h63: begin
            case (f3)
                3'd0: tk = (a == b);
                3'd1: tk = (a != b);
                3'd4: tk = $signed(a) < $signed(b);
                3'd5: tk = $signed(a) >= $signed(b);
                3'd6: tk = a < b;
                3'd7: tk = a >= b;
                default: bad = 1'b1;
            endcase
            if (tk) next = mPc + immB;
        end
        7'h03: begin
            expAddr = a + immI;
            res     = mMem[expAddr[7:2]];
            wr      = 1'b1;
            bad     = (f3 != 3'd2) || (expAddr[1:0] != 2'b00);
        end
        7'h23: begin
            expAddr  = a + immS;
            expWdata = b;
            expWen   = 1'b1;
            bad      = (f3 != 3'd2) || (expAddr[1:0] != 2'b00);
        end
        7'h13: begin
            res = arith(f3, (f3 == 3'd5) && f7[5], a, immI);
            wr  = 1'b1;
            bad = ((f3 == 3'd1) && (f7 != 7'h00)) ||
                  ((f3 == 3'd5) && (f7 != 7'h00) && (f7 != 7'h20));
        end
        7'h33: begin
            res = arith(f3, f7[5], a, b);
            wr  = 1'b1;
            bad = (f7 != 7'h00) && !((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
        end
        default: bad = 1'b1;
    endcase
    expHalt = bad;
    if (bad) begin
        expWen = 1'b0; // halted, state frozen
    end else begin
        if (wr && (w[11:7] != 5'd0)) mRegs[w[11:7]] = res;
        if (expWen) mMem[expAddr[7:2]] = b;
        mPc = next;
    end
endtask

// File: test/tbSingleCycleCpu.sv
`timescale 1ns/10ps

module tbSingleCycleCpu;

    localparam logic [31:0] resetPc = 32'h0000_0400; // pc[9:2] still starts at word 0
    localparam int progWords      = 256;
    localparam int passes         = 3;
    localparam int holdCycles     = 4;   // cycles watched after halt
    localparam int watchdogCycles = passes * (progWords * 2 + 16);

    logic          clk;
    logic          rst;
    logic [31:0]   pc;
    logic [31:0]   instr;
    logic [31:0]   dRdata;
    rvPkg::dataReq dReq;
    logic          halt;
    logic [31:0]   imem [progWords];
    logic [31:0]   dmem [64];
    int            errors;

    `include "isaModel.svh"

    singleCycleCpu #(.resetAddr(resetPc)) dut (
        .clk    (clk),
        .rst    (rst),
        .pc     (pc),
        .instr  (instr),
        .dReq   (dReq),
        .dRdata (dRdata),
        .halt   (halt)
    );

    assign instr  = imem[pc[9:2]];
    assign dRdata = dmem[dReq.addr[7:2]]; // window is 256-byte aligned

    always @(posedge clk) begin
        if (dReq.wen) dmem[dReq.addr[7:2]] <= dReq.wdata;
    end

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #(watchdogCycles * 100);
        $display("watchdog expired, the core never halted (%0d errors so far)", errors);
        $display("Testbench failed");
        $finish;
    end

    task automatic reportMismatch(input string testName, input string what,
                                  input logic [31:0] exp, input logic [31:0] act);
        errors++;
        $display("[ERROR] %s %s expected %h actual %h", testName, what, exp, act);
    endtask

    // one legal instruction, forward-only control flow
    function automatic logic [31:0] genInstr(input int idx);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [31:0] off;
        logic        alt;
        int          k;
        int          kind;
        rd   = 5'($urandom_range(30)); // x31 stays the data pointer
        rs1  = 5'($urandom);
        rs2  = 5'($urandom);
        f3   = 3'($urandom);
        imm  = 12'($urandom);
        alt  = 1'($urandom_range(1));
        k    = 1 + int'($urandom_range(3));
        kind = int'($urandom_range(9));
        if (idx + k > progWords - 1) k = progWords - 1 - idx;
        off = 32'(k * 4);
        case (kind)
            0, 1: return {(alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                          rs2, rs1, f3, rd, 7'h33};
            2, 3: begin
                if (f3 == 3'd1) imm = {7'h00, imm[4:0]};
                if (f3 == 3'd5) imm = {alt ? 7'h20 : 7'h00, imm[4:0]};
                return {imm, rs1, f3, rd, 7'h13};
            end
            4: return {20'($urandom), rd, alt ? 7'h37 : 7'h17};
            5: return {12'($urandom_range(63) * 4), 5'd31, 3'd2, rd, 7'h03};
            6, 7: begin
                imm = 12'($urandom_range(63) * 4);
                return {imm[11:5], rs2, 5'd31, 3'd2, imm[4:0], 7'h23};
            end
            8: begin
                f3 = 3'($urandom_range(5));
                if (f3 >= 3'd2) f3 = f3 + 3'd2; // skip the two reserved codes
                return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
            end
            default: begin
                if (alt) return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
                // absolute target from x0, bit 0 gets cleared
                off = resetPc + 32'(idx * 4) + off + 32'($urandom_range(1));
                return {off[11:0], 5'd0, 3'd0, rd, 7'h67};
            end
        endcase
    endfunction

    task automatic loadProgram(input logic [31:0] lastWord);
        imem[0] = {20'h00001, 5'd31, 7'h37}; // lui x31, data window base
        for (int i = 1; i < progWords - 1; i++) begin
            imem[i] = genInstr(i);
        end
        imem[progWords-1] = lastWord;
        foreach (dmem[i]) dmem[i] = fillWord(dataBase + 32'(i * 4));
    endtask

    task automatic runPass(input string name, input logic [31:0] lastWord);
        int          held;
        logic [31:0] firstWord;
        held = 0;
        @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        loadProgram(lastWord);
        modelReset();
        firstWord = imem[0];
        imem[0]   = {7'h00, 5'd0, 5'd0, 3'd2, 5'd0, 7'h23}; // sw x0, 0(x0) under reset
        repeat (4) begin
            @(posedge clk);
            @(negedge clk);
            assert (pc == resetPc) else reportMismatch(name, "reset pc", resetPc, pc);
            assert (!dReq.wen) else reportMismatch(name, "reset wen", 0, 32'(dReq.wen));
        end
        imem[0] = firstWord;
        @(posedge clk);
        rst <= 1'b1;
        while (held < holdCycles) begin
            @(negedge clk);
            modelStep();
            assert (pc == expPc) else reportMismatch(name, "pc", expPc, pc);
            assert (halt == expHalt) else reportMismatch(name, "halt", 32'(expHalt), 32'(halt));
            assert (dReq.wen == expWen)
                else reportMismatch(name, "wen", 32'(expWen), 32'(dReq.wen));
            assert (dReq.addr == expAddr)
                else reportMismatch(name, "data addr", expAddr, dReq.addr);
            if (expWen) begin
                assert (dReq.wdata == expWdata)
                    else reportMismatch(name, "store data", expWdata, dReq.wdata);
            end
            if (expHalt) held++;
            @(posedge clk);
        end
    endtask

    initial begin
        rst    = 1'b0;
        errors = 0;
        void'($urandom(32'h03c5_a72b));
        foreach (imem[i]) imem[i] = '0;
        foreach (dmem[i]) dmem[i] = fillWord(dataBase + 32'(i * 4));
        // funct7 of 1 on add is an illegal encoding
        runPass("illegalEnd", {7'h01, 5'd2, 5'd1, 3'd0, 5'd3, 7'h33});
        // lw x1, 2(x31) is misaligned
        runPass("misalignedEnd", {12'd2, 5'd31, 3'd2, 5'd1, 7'h03});
        // sb x1, 0(x31) is not part of this core
        runPass("illegalStore", {7'h00, 5'd1, 5'd31, 3'd0, 5'd0, 7'h23});
        $display("checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
